// ==== Bender.yml ====
package:
  name: dma_single

sources:
  - verilog/dma_pkg.sv
  - verilog/word_ram.sv
  - verilog/mem_arbiter.sv
  - verilog/dma_mover.sv
  - verilog/dma_regs.sv
  - verilog/dma_launcher.sv
  - verilog/dma_single_top.sv
  - target: test
    files:
      - tb/dma_single_tb.sv

// ==== dma_single_top.f ====
verilog/dma_pkg.sv
verilog/word_ram.sv
verilog/mem_arbiter.sv
verilog/dma_mover.sv
verilog/dma_regs.sv
verilog/dma_launcher.sv
verilog/dma_single_top.sv
tb/dma_single_tb.sv

// ==== tb/dma_single_tb.sv ====
/* Testbench for the single transfer DMA subsystem
   Random copies and host traffic checked against a memory model */
`timescale 1ns/1ps

module dma_single_tb;
    import dma_pkg::*;

    localparam int NUM_XFERS      = 40;
    localparam int NUM_PROBES     = 16;
    localparam int TIMEOUT_CYCLES = NUM_XFERS * (MAX_LEN * 8 + 20) + 600;

    logic              clk;
    logic              rst;
    logic              start;
    logic [MEM_AW-1:0] src_addr;
    logic [MEM_AW-1:0] dst_addr;
    logic [LEN_W-1:0]  len;
    mem_req_t          host_req;
    logic              done;
    logic              busy;
    logic [DATA_W-1:0] host_rdata;
    logic              host_rvalid;

    integer            seed = 32'h564826af;
    int                cycle_count = 0;
    int                done_count;
    int                start_count;
    logic [DATA_W-1:0] model [2**MEM_AW];
    logic              rd_pending;
    logic [DATA_W-1:0] rd_expect;
    logic [MEM_AW-1:0] xfer_src;
    logic [MEM_AW-1:0] xfer_dst;
    logic [LEN_W-1:0]  xfer_len;

    dma_single_top uut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .src_addr    (src_addr),
        .dst_addr    (dst_addr),
        .len         (len),
        .host_req    (host_req),
        .done        (done),
        .busy        (busy),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        assert (actual === expected)
        else begin
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    function automatic mem_req_t host_read(input logic [MEM_AW-1:0] a);
        mem_req_t r;
        r       = '0;
        r.valid = 1'b1;
        r.addr  = a;
        return r;
    endfunction

    function automatic mem_req_t host_write(input logic [MEM_AW-1:0] a,
                                            input logic [DATA_W-1:0] d);
        mem_req_t r;
        r       = host_read(a);
        r.we    = 1'b1;
        r.wdata = d;
        return r;
    endfunction

    // One clock: drive at the rising edge, sample at the falling edge
    task automatic run_cycle(input logic start_in, input mem_req_t req_in);
        @(posedge clk);
        start    <= start_in;
        src_addr <= xfer_src;
        dst_addr <= xfer_dst;
        len      <= xfer_len;
        host_req <= req_in;
        @(negedge clk);
        // Read data answers the request of the previous cycle
        check_value("host_rvalid", rd_pending, host_rvalid);
        if (rd_pending) begin
            check_value("host_rdata", rd_expect, host_rdata);
        end
        rd_pending = req_in.valid && !req_in.we;
        rd_expect  = model[req_in.addr];
        if (req_in.valid && req_in.we) begin
            model[req_in.addr] = req_in.wdata;
        end
        if (done) begin
            done_count++;
        end
    endtask

    task automatic run_transfer(input logic [MEM_AW-1:0] s, input logic [MEM_AW-1:0] d,
                                input logic [LEN_W-1:0] n);
        int unsigned       offs;
        logic [MEM_AW-1:0] a;
        mem_req_t          r;
        xfer_src = s;
        xfer_dst = d;
        xfer_len = n;
        run_cycle(1'b1, '0);
        start_count++;
        check_value("busy", 1'b0, busy);
        run_cycle(1'b0, '0);
        check_value("busy", 1'b1, busy);
        while (!done) begin
            r = '0;
            if ($random(seed) & 1) begin
                // Anywhere except the destination window
                offs = $unsigned($random(seed)) % (2**MEM_AW - n);
                a    = d + n + offs[MEM_AW-1:0];
                r    = host_read(a);
            end
            run_cycle(1'b0, r);
            if (!done) begin
                check_value("busy", 1'b1, busy);
            end
        end
        check_value("busy", 1'b0, busy);
        check_value("done count", start_count, done_count);
        // Forward copy, one word at a time
        for (int i = 0; i < n; i++) begin
            model[MEM_AW'(d + i)] = model[MEM_AW'(s + i)];
        end
    endtask

    initial begin
        int                gap;
        logic [MEM_AW-1:0] s;
        logic [MEM_AW-1:0] d;
        logic [LEN_W-1:0]  n;
        logic [MEM_AW-1:0] probe;
        rst         = 1'b1;
        start       = 1'b0;
        src_addr    = '0;
        dst_addr    = '0;
        len         = '0;
        host_req    = '0;
        xfer_src    = '0;
        xfer_dst    = '0;
        xfer_len    = '0;
        rd_pending  = 1'b0;
        rd_expect   = '0;
        done_count  = 0;
        start_count = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("busy", 1'b0, busy);
        check_value("done", 1'b0, done);

        // Fill the whole RAM so every later read is known
        for (int a = 0; a < 2**MEM_AW; a++) begin
            run_cycle(1'b0, host_write(a, $random(seed)));
        end

        // Host write at a random address, read back in the next cycle
        for (int i = 0; i < NUM_PROBES; i++) begin
            probe = $random(seed);
            run_cycle(1'b0, host_write(probe, $random(seed)));
            run_cycle(1'b0, host_read(probe));
        end
        run_cycle(1'b0, '0);

        // Every other transfer starts right after the previous done
        for (int t = 0; t < NUM_XFERS; t++) begin
            gap = (t % 2 == 0) ? 0 : $unsigned($random(seed)) % 3;
            repeat (gap) run_cycle(1'b0, '0);
            s = $random(seed);
            d = $random(seed);
            n = 1 + $unsigned($random(seed)) % MAX_LEN;
            run_transfer(s, d, n);
        end

        // Whole memory against the model
        for (int a = 0; a < 2**MEM_AW; a++) begin
            run_cycle(1'b0, host_read(a));
        end
        run_cycle(1'b0, '0);
        check_value("done count", NUM_XFERS, done_count);

        $display("Test OK");
        $finish;
    end

endmodule

// ==== verilog/dma_launcher.sv ====
/* Single transfer launcher
   Programs the copy engine, clears its interrupt and reports completion */
`timescale 1ns/1ps

module dma_launcher (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic [dma_pkg::MEM_AW-1:0]  src_addr,
    input  logic [dma_pkg::MEM_AW-1:0]  dst_addr,
    input  logic [dma_pkg::LEN_W-1:0]   len,
    input  logic                        irq,
    output dma_pkg::reg_wr_t            reg_wr,
    output logic                        done,
    output logic                        busy
);
    import dma_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SRC,
        ST_DST,
        ST_BTT,
        ST_WAIT
    } step_t;

    step_t             step;
    logic [MEM_AW-1:0] src_q;
    logic [MEM_AW-1:0] dst_q;
    logic [LEN_W-1:0]  len_q;
    logic              irq_q;
    logic              irq_rise;
    logic              clr_d;
    dma_reg_word_u     ctrl_word;
    dma_reg_word_u     clr_word;

    // Fixed words for the control write and the interrupt clear
    always_comb begin
        ctrl_word = '0;
        ctrl_word.ctrl.irq_en = 1'b1;
        clr_word = '0;
        clr_word.status.ioc_irq = 1'b1;
    end

    assign irq_rise = irq && !irq_q && (step == ST_WAIT);

    // Request capture
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            src_q <= src_addr;
            dst_q <= dst_addr;
            len_q <= len;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step   <= ST_IDLE;
            reg_wr <= '0;
            irq_q  <= 1'b0;
            clr_d  <= 1'b0;
            done   <= 1'b0;
            busy   <= 1'b0;
        end else begin
            irq_q        <= irq;
            clr_d        <= irq_rise;
            done         <= clr_d;
            reg_wr.valid <= 1'b0;
            if (clr_d) begin
                busy <= 1'b0;
            end
            case (step)
                ST_IDLE: begin
                    if (start && !busy) begin
                        busy         <= 1'b1;
                        step         <= ST_SRC;
                        reg_wr.valid <= 1'b1;
                        reg_wr.addr  <= REG_CTRL;
                        reg_wr.data  <= ctrl_word;
                    end
                end
                ST_SRC: begin
                    step         <= ST_DST;
                    reg_wr.valid <= 1'b1;
                    reg_wr.addr  <= REG_SRC;
                    reg_wr.data  <= {{(DATA_W-MEM_AW-2){1'b0}}, src_q, 2'b00};
                end
                ST_DST: begin
                    step         <= ST_BTT;
                    reg_wr.valid <= 1'b1;
                    reg_wr.addr  <= REG_DST;
                    reg_wr.data  <= {{(DATA_W-MEM_AW-2){1'b0}}, dst_q, 2'b00};
                end
                ST_BTT: begin
                    // Byte count, length in words times four
                    step         <= ST_WAIT;
                    reg_wr.valid <= 1'b1;
                    reg_wr.addr  <= REG_BTT;
                    reg_wr.data  <= {{(DATA_W-LEN_W-2){1'b0}}, len_q, 2'b00};
                end
                default: begin
                    // Write-one-to-clear the completion flag
                    if (irq_rise) begin
                        step         <= ST_IDLE;
                        reg_wr.valid <= 1'b1;
                        reg_wr.addr  <= REG_STATUS;
                        reg_wr.data  <= clr_word;
                    end
                end
            endcase
        end
    end

    a_no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy)
        else $error("start issued while a transfer is in flight");

endmodule

// ==== verilog/dma_mover.sv ====
/* Word copy engine
   Reads each source word and writes it to the destination through the arbiter */
`timescale 1ns/1ps

module dma_mover (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        go,
    input  logic [dma_pkg::MEM_AW-1:0]  src_word,
    input  logic [dma_pkg::MEM_AW-1:0]  dst_word,
    input  logic [dma_pkg::BTT_W-1:0]   btt,
    input  logic                        gnt,
    input  logic                        rd_valid,
    input  logic [dma_pkg::DATA_W-1:0]  rdata,
    output dma_pkg::mem_req_t           req,
    output logic                        idle,
    output logic                        xfer_done
);
    import dma_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_RD,
        S_RD_WAIT,
        S_WR
    } state_t;

    state_t            state;
    logic [LEN_W-1:0]  remain;
    logic [LEN_W-1:0]  btt_words;
    logic [MEM_AW-1:0] rd_ptr;
    logic [MEM_AW-1:0] wr_ptr;
    logic [DATA_W-1:0] data_q;
    logic              last_wr;

    assign btt_words = btt[BTT_W-1:2];
    assign last_wr   = (state == S_WR) && gnt && (remain == LEN_W'(1));
    assign idle      = (state == S_IDLE);

    // Request is a function of state only, so it holds while waiting
    always_comb begin
        req.valid = (state == S_RD) || (state == S_WR);
        req.we    = (state == S_WR);
        req.addr  = (state == S_WR) ? wr_ptr : rd_ptr;
        req.wdata = data_q;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            remain    <= '0;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= last_wr || (go && idle && btt_words == '0);
            case (state)
                S_IDLE: begin
                    if (go && btt_words != '0) begin
                        remain <= btt_words;
                        state  <= S_RD;
                    end
                end
                S_RD: begin
                    if (gnt) begin
                        state <= S_RD_WAIT;
                    end
                end
                S_RD_WAIT: begin
                    if (rd_valid) begin
                        state <= S_WR;
                    end
                end
                default: begin
                    if (gnt) begin
                        remain <= remain - 1'b1;
                        state  <= last_wr ? S_IDLE : S_RD;
                    end
                end
            endcase
        end
    end

    // Address pointers and the word in transit
    always_ff @(posedge clk) begin
        if (go && idle) begin
            rd_ptr <= src_word;
            wr_ptr <= dst_word;
        end else if (state == S_WR && gnt) begin
            rd_ptr <= rd_ptr + 1'b1;
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (state == S_RD_WAIT && rd_valid) begin
            data_q <= rdata;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (req.valid && !gnt) |=> $stable(req))
        else $error("mover request changed before grant");

endmodule

// ==== verilog/dma_pkg.sv ====
/* DMA subsystem shared definitions
   Sizes, register map, bus structs and the register write word */
package dma_pkg;

    localparam int DATA_W  = 32;
    localparam int MEM_AW  = 8;
    localparam int REG_AW  = 6;
    localparam int MAX_LEN = 16;

    // Length in words and byte count widths
    localparam int LEN_W = $clog2(MAX_LEN) + 1;
    localparam int BTT_W = LEN_W + 2;

    // Register byte offsets
    localparam logic [REG_AW-1:0] REG_CTRL   = 6'h00;
    localparam logic [REG_AW-1:0] REG_STATUS = 6'h04;
    localparam logic [REG_AW-1:0] REG_SRC    = 6'h18;
    localparam logic [REG_AW-1:0] REG_DST    = 6'h20;
    localparam logic [REG_AW-1:0] REG_BTT    = 6'h28;

    // Control register, interrupt enable at bit 12
    typedef struct packed {
        logic [18:0] rsvd_hi;
        logic        irq_en;
        logic [11:0] rsvd_lo;
    } dma_ctrl_t;

    // Status register, completion flag at bit 12 and idle at bit 1
    typedef struct packed {
        logic [18:0] rsvd_hi;
        logic        ioc_irq;
        logic [9:0]  rsvd_mid;
        logic        idle;
        logic        rsvd_lo;
    } dma_status_t;

    typedef union packed {
        dma_ctrl_t   ctrl;
        dma_status_t status;
    } dma_reg_word_u;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] addr;
        logic [DATA_W-1:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic [MEM_AW-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

endpackage

// ==== verilog/dma_regs.sv ====
/* Copy engine register block
   Decodes register writes, launches the engine and raises the interrupt */
`timescale 1ns/1ps

module dma_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  dma_pkg::reg_wr_t            reg_wr,
    input  logic                        idle,
    input  logic                        xfer_done,
    output logic                        go,
    output logic [dma_pkg::MEM_AW-1:0]  src_word,
    output logic [dma_pkg::MEM_AW-1:0]  dst_word,
    output logic [dma_pkg::BTT_W-1:0]   btt,
    output logic                        irq
);
    import dma_pkg::*;

    dma_reg_word_u wr_word;
    logic          wr_ctrl;
    logic          wr_status;
    logic          wr_src;
    logic          wr_dst;
    logic          wr_btt;
    logic          irq_en;
    logic          ioc_irq;

    assign wr_word   = reg_wr.data;
    assign wr_ctrl   = reg_wr.valid && (reg_wr.addr == REG_CTRL);
    assign wr_status = reg_wr.valid && (reg_wr.addr == REG_STATUS);
    assign wr_src    = reg_wr.valid && (reg_wr.addr == REG_SRC);
    assign wr_dst    = reg_wr.valid && (reg_wr.addr == REG_DST);
    assign wr_btt    = reg_wr.valid && (reg_wr.addr == REG_BTT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            go      <= 1'b0;
            irq_en  <= 1'b0;
            ioc_irq <= 1'b0;
        end else begin
            go <= wr_btt;
            if (wr_ctrl) begin
                irq_en <= wr_word.ctrl.irq_en;
            end
            // A completing transfer wins over a clear in the same cycle
            if (xfer_done) begin
                ioc_irq <= 1'b1;
            end else if (wr_status && wr_word.status.ioc_irq) begin
                ioc_irq <= 1'b0;
            end
        end
    end

    // Byte addresses become word addresses
    always_ff @(posedge clk) begin
        if (wr_src) begin
            src_word <= reg_wr.data[MEM_AW+1:2];
        end
        if (wr_dst) begin
            dst_word <= reg_wr.data[MEM_AW+1:2];
        end
        if (wr_btt) begin
            btt <= reg_wr.data[BTT_W-1:0];
        end
    end

    assign irq = irq_en && ioc_irq;

    a_btt_when_idle: assert property (@(posedge clk) disable iff (rst)
        wr_btt |-> idle)
        else $error("byte count written while the engine is busy");

endmodule

// ==== verilog/dma_single_top.sv ====
/* Single transfer DMA subsystem
   Launcher, engine registers, mover, arbiter and shared RAM */
`timescale 1ns/1ps

module dma_single_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic [dma_pkg::MEM_AW-1:0]  src_addr,
    input  logic [dma_pkg::MEM_AW-1:0]  dst_addr,
    input  logic [dma_pkg::LEN_W-1:0]   len,
    input  dma_pkg::mem_req_t           host_req,
    output logic                        done,
    output logic                        busy,
    output logic [dma_pkg::DATA_W-1:0]  host_rdata,
    output logic                        host_rvalid
);
    import dma_pkg::*;

    reg_wr_t           reg_wr;
    logic              go;
    logic [MEM_AW-1:0] src_word;
    logic [MEM_AW-1:0] dst_word;
    logic [BTT_W-1:0]  btt;
    logic              irq;
    logic              idle;
    logic              xfer_done;
    mem_req_t          dma_req;
    mem_req_t          ram_req;
    logic              dma_gnt;
    logic              dma_rd_valid;

    dma_launcher u_launcher (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .src_addr (src_addr),
        .dst_addr (dst_addr),
        .len      (len),
        .irq      (irq),
        .reg_wr   (reg_wr),
        .done     (done),
        .busy     (busy)
    );

    dma_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .reg_wr    (reg_wr),
        .idle      (idle),
        .xfer_done (xfer_done),
        .go        (go),
        .src_word  (src_word),
        .dst_word  (dst_word),
        .btt       (btt),
        .irq       (irq)
    );

    dma_mover u_mover (
        .clk       (clk),
        .rst       (rst),
        .go        (go),
        .src_word  (src_word),
        .dst_word  (dst_word),
        .btt       (btt),
        .gnt       (dma_gnt),
        .rd_valid  (dma_rd_valid),
        .rdata     (host_rdata),
        .req       (dma_req),
        .idle      (idle),
        .xfer_done (xfer_done)
    );

    // RAM read data is shared by both requesters
    mem_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .host_req     (host_req),
        .dma_req      (dma_req),
        .ram_rdata    (host_rdata),
        .dma_gnt      (dma_gnt),
        .dma_rd_valid (dma_rd_valid),
        .host_rvalid  (host_rvalid),
        .ram_req      (ram_req)
    );

    word_ram u_ram (
        .clk   (clk),
        .req   (ram_req),
        .rdata (host_rdata)
    );

endmodule

// ==== verilog/mem_arbiter.sv ====
/* RAM port arbiter
   Host first, mover otherwise; routes the read-valid strobe to the reader */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  dma_pkg::mem_req_t           host_req,
    input  dma_pkg::mem_req_t           dma_req,
    input  logic [dma_pkg::DATA_W-1:0]  ram_rdata,
    output logic                        dma_gnt,
    output logic                        dma_rd_valid,
    output logic                        host_rvalid,
    output dma_pkg::mem_req_t           ram_req
);
    import dma_pkg::*;

    logic host_rd;
    logic dma_rd;

    // The host never waits
    assign dma_gnt = dma_req.valid && !host_req.valid;
    assign ram_req = host_req.valid ? host_req : dma_req;

    assign host_rd = host_req.valid && !host_req.we;
    assign dma_rd  = dma_gnt && !dma_req.we;

    // Owner of the read in flight
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            host_rvalid  <= 1'b0;
            dma_rd_valid <= 1'b0;
        end else begin
            host_rvalid  <= host_rd;
            dma_rd_valid <= dma_rd;
        end
    end

    a_rdata_known: assert property (@(posedge clk) disable iff (rst)
        (host_rvalid || dma_rd_valid) |-> !$isunknown(ram_rdata))
        else $error("RAM returned unknown data for a granted read");

endmodule

// ==== verilog/word_ram.sv ====
/* Single-port word RAM, 256 x 32, one-cycle read latency */
`timescale 1ns/1ps

module word_ram (
    input  logic                        clk,
    input  dma_pkg::mem_req_t           req,
    output logic [dma_pkg::DATA_W-1:0]  rdata
);
    import dma_pkg::*;

    logic [DATA_W-1:0] mem [2**MEM_AW];

    always_ff @(posedge clk) begin
        if (req.valid) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rdata <= mem[req.addr];
            end
        end
    end

endmodule
